/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // data path and storage sizes
    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 32;
    localparam int REG_IDX_W   = $clog2(REG_COUNT);
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_IDX_W  = $clog2(DMEM_WORDS);

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,
        PASS_B
    } alu_op_e;

    // raw opcode kept as plain bits, illegal values must survive
    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } instr_t;

    // decode to execute
    typedef struct packed {
        logic                 valid;
        instr_t               inst;
        alu_op_e              alu_op;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic [REG_IDX_W-1:0] rd;
        logic                 reg_write;
        logic                 is_load;
        logic                 is_store;
        logic                 trap;
    } dx_rec_t;

    // execute to memory, operand values as seen after forwarding
    typedef struct packed {
        logic                 valid;
        instr_t               inst;
        logic [REG_IDX_W-1:0] rd;
        logic                 reg_write;
        logic                 is_load;
        logic                 is_store;
        logic                 trap;
        logic [XLEN-1:0]      alu_result;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      store_data;
    } xm_rec_t;

    // memory to writeback
    typedef struct packed {
        logic                 valid;
        instr_t               inst;
        logic [REG_IDX_W-1:0] rd;
        logic                 reg_write;
        logic                 is_load;
        logic                 is_store;
        logic                 trap;
        logic [XLEN-1:0]      alu_result;
        logic [XLEN-1:0]      rs1_val;
        logic [XLEN-1:0]      rs2_val;
        logic [XLEN-1:0]      store_data;
        logic [XLEN-1:0]      load_data;
    } mw_rec_t;

    // one retirement, in the style of a retirement monitor
    typedef struct packed {
        logic                 valid;
        logic [31:0]          order;
        instr_t               inst;
        logic                 trap;
        logic [REG_IDX_W-1:0] rd_addr;
        logic [XLEN-1:0]      rd_wdata;
        logic                 load_regfile;
        logic [XLEN-1:0]      mem_addr;
        logic [3:0]           mem_rmask;
        logic [3:0]           mem_wmask;
        logic [XLEN-1:0]      mem_wdata;
        logic [XLEN-1:0]      mem_rdata;
    } commit_t;

endpackage

`default_nettype wire

/* src/instr_queue.sv */
`default_nettype none

module instr_queue import core_pkg::*; (
    input  logic   itf,
    input  logic   rst_n,
    input  logic   instr_valid,
    input  instr_t instr,
    input  logic   take,
    output logic   head_valid,
    output instr_t head,
    output logic   credit_return
);

    instr_t            buffer [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;
    logic              push;
    logic              pop;

    // sender holds a credit for every free slot
    assign push = instr_valid;
    assign pop  = take && head_valid;

    assign head_valid    = (count != '0);
    assign head          = buffer[rd_ptr];
    // one credit back per word handed to decode
    assign credit_return = pop;

    // entries carry no reset, count decides what is live
    always_ff @(posedge itf) begin
        if (push) begin
            buffer[wr_ptr] <= instr;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sender must have run out of credits before the buffer fills
    a_no_push_when_full: assert property (
        @(posedge itf) disable iff (!rst_n)
        push |-> (count != QUEUE_DEPTH[QPTR_W:0])
    );

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic                 itf,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] rs1_idx,
    input  logic [REG_IDX_W-1:0] rs2_idx,
    output logic [XLEN-1:0]      rs1_val,
    output logic [XLEN-1:0]      rs2_val,
    input  logic                 wr_en,
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [XLEN-1:0]      wr_data
);

    logic [XLEN-1:0] regs [REG_COUNT];

    // architectural state starts at zero, x0 never written
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through, covers writeback and decode in the same cycle
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (wr_en && (wr_idx == rs1_idx)) ? wr_data : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (wr_en && (wr_idx == rs2_idx)) ? wr_data : regs[rs2_idx];

    // writeback filters rd == 0 before it reaches the port
    a_no_x0_store: assert property (
        @(posedge itf) disable iff (!rst_n)
        wr_en |-> (wr_idx != '0)
    );

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic                 itf,
    input  logic                 rst_n,
    input  logic                 head_valid,
    input  instr_t               head,
    output logic                 take,
    output logic [REG_IDX_W-1:0] rs1_idx,
    output logic [REG_IDX_W-1:0] rs2_idx,
    input  logic [XLEN-1:0]      rs1_val,
    input  logic [XLEN-1:0]      rs2_val,
    output dx_rec_t              dx
);

    logic            legal;
    alu_op_e         alu_op;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            reg_write;
    logic            is_load;
    logic            is_store;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            load_use;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;

    // immediate formats, sign bit is funct7[6]
    assign imm_i = {{20{head.funct7[6]}}, head.funct7, head.rs2};
    assign imm_s = {{20{head.funct7[6]}}, head.funct7, head.rd};
    assign imm_u = {head.funct7, head.rs2, head.rs1, head.funct3, 12'h000};

    always_comb begin
        legal     = 1'b1;
        alu_op    = ADD;
        imm       = imm_i;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        is_load   = 1'b0;
        is_store  = 1'b0;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        case (opcode_e'(head.opcode))
            OP: begin
                use_imm  = 1'b0;
                uses_rs2 = 1'b1;
                // only sub carries a nonzero funct7
                legal = (head.funct7 == 7'h00) ||
                        ((head.funct7 == 7'h20) && (head.funct3 == 3'b000));
                case (head.funct3)
                    3'b000:  alu_op = head.funct7[5] ? SUB : ADD;
                    3'b001:  alu_op = SLL;
                    3'b010:  alu_op = SLT;
                    3'b100:  alu_op = XOR;
                    3'b101:  alu_op = SRL;
                    3'b110:  alu_op = OR;
                    3'b111:  alu_op = AND;
                    default: legal = 1'b0;
                endcase
            end
            OP_IMM: begin
                case (head.funct3)
                    3'b000:  alu_op = ADD;
                    3'b100:  alu_op = XOR;
                    3'b110:  alu_op = OR;
                    3'b111:  alu_op = AND;
                    default: legal = 1'b0;
                endcase
            end
            LUI: begin
                alu_op   = PASS_B;
                imm      = imm_u;
                uses_rs1 = 1'b0;
            end
            // word accesses only
            LOAD: begin
                is_load = 1'b1;
                legal   = (head.funct3 == 3'b010);
            end
            STORE: begin
                is_store  = 1'b1;
                reg_write = 1'b0;
                uses_rs2  = 1'b1;
                imm       = imm_s;
                legal     = (head.funct3 == 3'b010);
            end
            default: legal = 1'b0;
        endcase
        // trapped instructions retire with no side effects
        if (!legal) begin
            reg_write = 1'b0;
            is_load   = 1'b0;
            is_store  = 1'b0;
            uses_rs1  = 1'b0;
            uses_rs2  = 1'b0;
        end
    end

    assign rs1_idx = head.rs1;
    assign rs2_idx = head.rs2;

    // load one stage ahead feeding this word, hold for a cycle
    assign load_use = dx.valid && dx.is_load && (dx.rd != '0) &&
                      ((uses_rs1 && (dx.rd == head.rs1)) ||
                       (uses_rs2 && (dx.rd == head.rs2)));

    assign take = head_valid && !load_use;

    // a stall leaves valid low, so execute sees a bubble
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid     <= take;
            dx.inst      <= head;
            dx.alu_op    <= alu_op;
            dx.rs1       <= head.rs1;
            dx.rs2       <= head.rs2;
            dx.rs1_val   <= rs1_val;
            dx.rs2_val   <= rs2_val;
            dx.imm       <= imm;
            dx.use_imm   <= use_imm;
            dx.rd        <= head.rd;
            dx.reg_write <= reg_write;
            dx.is_load   <= is_load;
            dx.is_store  <= is_store;
            dx.trap      <= !legal;
        end
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic            itf,
    input  logic            rst_n,
    input  dx_rec_t         dx,
    input  xm_rec_t         xm_fwd,
    input  mw_rec_t         mw_fwd,
    input  logic [XLEN-1:0] mw_result,
    output xm_rec_t         xm
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;

    // newest producer wins, x0 is never forwarded
    function automatic logic [XLEN-1:0] forward(
        input logic [REG_IDX_W-1:0] idx,
        input logic [XLEN-1:0]      reg_val
    );
        logic xm_hit;
        logic mw_hit;
        // load address is not a result, load-use stall keeps this case out
        xm_hit = xm_fwd.valid && xm_fwd.reg_write && !xm_fwd.is_load &&
                 (xm_fwd.rd == idx);
        mw_hit = mw_fwd.valid && mw_fwd.reg_write && (mw_fwd.rd == idx);
        if (idx == '0) begin
            return '0;
        end else if (xm_hit) begin
            return xm_fwd.alu_result;
        end else if (mw_hit) begin
            return mw_result;
        end
        return reg_val;
    endfunction

    assign op_a     = forward(dx.rs1, dx.rs1_val);
    assign op_b_reg = forward(dx.rs2, dx.rs2_val);
    assign op_b     = dx.use_imm ? dx.imm : op_b_reg;

    // loads and stores go through ADD for the address
    always_comb begin
        case (dx.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            AND:     alu_result = op_a & op_b;
            OR:      alu_result = op_a | op_b;
            XOR:     alu_result = op_a ^ op_b;
            SLL:     alu_result = op_a << op_b[4:0];
            SRL:     alu_result = op_a >> op_b[4:0];
            SLT:     alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            PASS_B:  alu_result = op_b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            xm.valid <= 1'b0;
        end else begin
            xm.valid      <= dx.valid;
            xm.inst       <= dx.inst;
            xm.rd         <= dx.rd;
            xm.reg_write  <= dx.reg_write;
            xm.is_load    <= dx.is_load;
            xm.is_store   <= dx.is_store;
            xm.trap       <= dx.trap;
            xm.alu_result <= alu_result;
            // operand values as the retirement record reports them
            xm.rs1_val    <= op_a;
            xm.rs2_val    <= op_b_reg;
            xm.store_data <= dx.is_store ? op_b_reg : '0;
        end
    end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`default_nettype none

module memory_stage import core_pkg::*; (
    input  logic    itf,
    input  logic    rst_n,
    input  xm_rec_t xm,
    output mw_rec_t mw
);

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;

    // word index from address bits 7..2, upper bits ignored
    assign word_idx = xm.alu_result[DMEM_IDX_W+1:2];

    // memory comes up cleared
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (xm.valid && xm.is_store) begin
            dmem[word_idx] <= xm.store_data;
        end
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            mw.valid <= 1'b0;
        end else begin
            mw.valid      <= xm.valid;
            mw.inst       <= xm.inst;
            mw.rd         <= xm.rd;
            mw.reg_write  <= xm.reg_write;
            mw.is_load    <= xm.is_load;
            mw.is_store   <= xm.is_store;
            mw.trap       <= xm.trap;
            mw.alu_result <= xm.alu_result;
            mw.rs1_val    <= xm.rs1_val;
            mw.rs2_val    <= xm.rs2_val;
            mw.store_data <= xm.store_data;
            // synchronous read, store one cycle earlier is already in
            mw.load_data  <= xm.is_load ? dmem[word_idx] : '0;
        end
    end

endmodule

`default_nettype wire

/* src/writeback_stage.sv */
`default_nettype none

module writeback_stage import core_pkg::*; (
    input  logic                 itf,
    input  logic                 rst_n,
    input  mw_rec_t              mw,
    output logic                 wr_en,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic [XLEN-1:0]      wr_data,
    output logic [XLEN-1:0]      mw_result,
    output commit_t              commit
);

    logic [31:0] order_cnt;

    assign mw_result = mw.is_load ? mw.load_data : mw.alu_result;

    // x0 writes retire but never reach the register file
    assign wr_en   = mw.valid && mw.reg_write && (mw.rd != '0);
    assign wr_idx  = mw.rd;
    assign wr_data = mw_result;

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            order_cnt    <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (mw.valid) begin
                order_cnt <= order_cnt + 1'b1;
            end
            commit.valid        <= mw.valid;
            commit.order        <= order_cnt;
            commit.inst         <= mw.inst;
            commit.trap         <= mw.trap;
            commit.rd_addr      <= mw.reg_write ? mw.rd : '0;
            commit.rd_wdata     <= mw.reg_write ? mw_result : '0;
            commit.load_regfile <= mw.reg_write;
            commit.mem_addr     <= (mw.is_load || mw.is_store) ? mw.alu_result : '0;
            commit.mem_rmask    <= mw.is_load ? 4'hF : 4'h0;
            commit.mem_wmask    <= mw.is_store ? 4'hF : 4'h0;
            commit.mem_wdata    <= mw.store_data;
            commit.mem_rdata    <= mw.load_data;
        end
    end

    // decode clears reg_write on a trap, checked here at retirement
    a_trap_no_write: assert property (
        @(posedge itf) disable iff (!rst_n)
        (commit.valid && commit.trap) |-> !commit.load_regfile
    );

endmodule

`default_nettype wire

/* src/core_top.sv */
`default_nettype none

module core_top import core_pkg::*; (
    input  logic    itf,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_t  instr,
    output logic    credit_return,
    output commit_t commit
);

    logic                 head_valid;
    instr_t               head;
    logic                 take;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;
    logic [XLEN-1:0]      mw_result;
    dx_rec_t              dx;
    xm_rec_t              xm;
    mw_rec_t              mw;

    instr_queue u_queue (
        .itf           (itf),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .take          (take),
        .head_valid    (head_valid),
        .head          (head),
        .credit_return (credit_return)
    );

    decode_stage u_decode (
        .itf        (itf),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .take       (take),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .dx         (dx)
    );

    // execute sees its own output and the memory output for forwarding
    execute_stage u_execute (
        .itf       (itf),
        .rst_n     (rst_n),
        .dx        (dx),
        .xm_fwd    (xm),
        .mw_fwd    (mw),
        .mw_result (mw_result),
        .xm        (xm)
    );

    memory_stage u_memory (
        .itf   (itf),
        .rst_n (rst_n),
        .xm    (xm),
        .mw    (mw)
    );

    writeback_stage u_writeback (
        .itf       (itf),
        .rst_n     (rst_n),
        .mw        (mw),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .mw_result (mw_result),
        .commit    (commit)
    );

    reg_file u_regs (
        .itf     (itf),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

/* sim/core_tb_table.svh */
`ifndef CORE_TB_TABLE_SVH
`define CORE_TB_TABLE_SVH

    task automatic fill_table();
        // columns: word, rd_addr, rd_wdata, load_regfile, trap, mem_addr, mem_rmask, mem_wmask
        // lui and immediate ops build constants
        add_row(32'h123450B7, 5'd1,  32'h12345000, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h67800113, 5'd2,  32'h00000678, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'hFFF08193, 5'd3,  32'h12344FFF, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h0F016213, 5'd4,  32'h000006F8, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h7FF24293, 5'd5,  32'h00000107, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h0FF1F313, 5'd6,  32'h000000FF, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        // back to back register ops, one and two back
        add_row(32'h006283B3, 5'd7,  32'h00000206, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h40238433, 5'd8,  32'hFFFFFB8E, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h007424B3, 5'd9,  32'h00000001, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h00939533, 5'd10, 32'h0000040C, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h009455B3, 5'd11, 32'h7FFFFDC7, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h00B54633, 5'd12, 32'h7FFFF9CB, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h002666B3, 5'd13, 32'h7FFFFFFB, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h0036F733, 5'd14, 32'h12344FFB, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        // store then load of word 0x40, then a dependent add
        add_row(32'h04E02023, 5'd0,  32'h00000000, 1'b0, 1'b0, 32'h40, 4'h0, 4'hF);
        add_row(32'h04002783, 5'd15, 32'h12344FFB, 1'b1, 1'b0, 32'h40, 4'hF, 4'h0);
        add_row(32'h00278833, 5'd16, 32'h12345673, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        // second load-use, dependency on rs2
        add_row(32'h05002223, 5'd0,  32'h00000000, 1'b0, 1'b0, 32'h44, 4'h0, 4'hF);
        add_row(32'h04402883, 5'd17, 32'h12345673, 1'b1, 1'b0, 32'h44, 4'hF, 4'h0);
        add_row(32'h01110933, 5'd18, 32'h12345CEB, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        // x0 target retires its value, x0 still reads zero
        add_row(32'h00510013, 5'd0,  32'h0000067D, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h010009B3, 5'd19, 32'h12345673, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        // illegal opcode 0x7f traps, later words unaffected
        add_row(32'hFFFFFFFF, 5'd0,  32'h00000000, 1'b0, 1'b1, 32'h0, 4'h0, 4'h0);
        add_row(32'h00198A13, 5'd20, 32'h12345674, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'hABCDEAB7, 5'd21, 32'hABCDE000, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
        add_row(32'h014A8B33, 5'd22, 32'hBE023674, 1'b1, 1'b0, 32'h0, 4'h0, 4'h0);
    endtask

`endif

/* sim/core_tb.sv */
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_ROW = 20;

    // one expected retirement per instruction word
    typedef struct packed {
        logic [31:0] word;
        logic [4:0]  rd_addr;
        logic [31:0] rd_wdata;
        logic        load_regfile;
        logic        trap;
        logic [31:0] mem_addr;
        logic [3:0]  mem_rmask;
        logic [3:0]  mem_wmask;
    } row_t;

    logic    itf;
    logic    rst_n;
    logic    instr_valid;
    instr_t  instr;
    logic    credit_return;
    commit_t commit;

    row_t        rows [$];
    logic [31:0] arch_regs [32];
    int          credits;
    int          sent;
    int          checked;
    int          failures;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] lcg_state;

    `include "core_tb_table.svh"

    core_top DUT (
        .itf           (itf),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .credit_return (credit_return),
        .commit        (commit)
    );

    always #5 itf = ~itf;

    task automatic add_row(
        input logic [31:0] word,
        input logic [4:0]  rd_addr,
        input logic [31:0] rd_wdata,
        input logic        load_regfile,
        input logic        trap,
        input logic [31:0] mem_addr,
        input logic [3:0]  mem_rmask,
        input logic [3:0]  mem_wmask
    );
        row_t r;
        r.word         = word;
        r.rd_addr      = rd_addr;
        r.rd_wdata     = rd_wdata;
        r.load_regfile = load_regfile;
        r.trap         = trap;
        r.mem_addr     = mem_addr;
        r.mem_rmask    = mem_rmask;
        r.mem_wmask    = mem_wmask;
        rows.push_back(r);
    endtask

    // full-period lcg, upper bits are the better ones
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_value(
        input string       what,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            failures++;
            $display("Fail at time %0t: %s expected %h got %h",
                     $time, what, expected, actual);
            stop_run();
        end
    endtask

    // order follows the tb's own retirement count
    task automatic check_commit(input row_t exp);
        string       tag;
        logic [31:0] exp_wdata;
        logic [31:0] exp_rdata;
        tag = $sformatf("commit %0d", checked);
        // a store writes its rs2 register, a load returns its rd value
        exp_wdata = (exp.mem_wmask != 4'h0) ? arch_regs[exp.word[24:20]] : 32'h0;
        exp_rdata = (exp.mem_rmask != 4'h0) ? exp.rd_wdata : 32'h0;
        check_value({tag, " order"}, commit.order, 32'(checked));
        check_value({tag, " inst"}, 32'(commit.inst), exp.word);
        check_value({tag, " rd_addr"}, 32'(commit.rd_addr), 32'(exp.rd_addr));
        check_value({tag, " rd_wdata"}, commit.rd_wdata, exp.rd_wdata);
        check_value({tag, " load_regfile"}, 32'(commit.load_regfile),
                    32'(exp.load_regfile));
        check_value({tag, " trap"}, 32'(commit.trap), 32'(exp.trap));
        check_value({tag, " mem_addr"}, commit.mem_addr, exp.mem_addr);
        check_value({tag, " mem_rmask"}, 32'(commit.mem_rmask), 32'(exp.mem_rmask));
        check_value({tag, " mem_wmask"}, 32'(commit.mem_wmask), 32'(exp.mem_wmask));
        check_value({tag, " mem_wdata"}, commit.mem_wdata, exp_wdata);
        check_value({tag, " mem_rdata"}, commit.mem_rdata, exp_rdata);
        // register state as the table retires it
        if (exp.load_regfile && (exp.rd_addr != 5'd0)) begin
            arch_regs[exp.rd_addr] = exp.rd_wdata;
        end
    endtask

    // credits: spent on a send, won back on each return pulse
    always @(posedge itf) begin
        if (!rst_n) begin
            credits = QUEUE_DEPTH;
        end else begin
            credits = credits - int'(instr_valid) + int'(credit_return);
            if (credits > QUEUE_DEPTH) begin
                $display("Credit overflow: more credits came back than were spent");
                stop_run();
            end
        end
    end

    always @(posedge itf) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: only %0d of %0d instructions retired in %0d cycles",
                     checked, rows.size(), cycle_limit);
            stop_run();
        end
    end

    // commit is registered, so the falling edge sees it settled
    always @(negedge itf) begin
        if (rst_n && commit.valid) begin
            if (checked >= rows.size()) begin
                $display("Unexpected commit at time %0t past the end of the table", $time);
                stop_run();
            end else begin
                check_commit(rows[checked]);
                checked = checked + 1;
            end
        end
    end

    initial begin
        logic [31:0] roll;
        itf         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        sent        = 0;
        checked     = 0;
        failures    = 0;
        cycle_count = 0;
        credits     = QUEUE_DEPTH;
        lcg_state   = 32'h4fd5_8584;
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = 32'h0;
        end
        fill_table();
        cycle_limit = rows.size() * CYCLES_PER_ROW + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge itf);
        #1;
        rst_n = 1'b1;
        // random gaps, sends also wait on credits
        while (sent < rows.size()) begin
            roll = lcg_next();
            if ((credits > 0) && (roll[31:30] != 2'b00)) begin
                instr_valid = 1'b1;
                instr       = instr_t'(rows[sent].word);
                sent        = sent + 1;
            end else begin
                instr_valid = 1'b0;
            end
            @(posedge itf);
            #1;
        end
        instr_valid = 1'b0;
        while (checked < rows.size()) begin
            @(negedge itf);
        end
        // idle core holds no credits
        check_value("idle credits", 32'(credits), 32'(QUEUE_DEPTH));
        if (failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+sim
src/core_pkg.sv
src/instr_queue.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/writeback_stage.sv
src/core_top.sv
sim/core_tb.sv

/* Makefile */
TOP = core_tb

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean
